// ==== verilog/uart_pkg.sv ====
package uart_pkg;

   // ####################
   // Line timing
   // ####################
   localparam int CLKS_PER_BIT = 8;               // Clocks per serial bit
   localparam int HALF_BIT     = 4;               // Mid-bit sample offset

   // ####################
   // Frame layout
   // ####################
   localparam int DATA_BITS  = 8;
   localparam int FRAME_BITS = DATA_BITS + 3;     // Start, data, parity, stop
   localparam int WORD_BITS  = 2 * FRAME_BITS;    // Two frames per command

   typedef logic [DATA_BITS-1:0]   byte_t;
   typedef logic [2*DATA_BITS-1:0] cmd_t;
   typedef logic [WORD_BITS-1:0]   tx_word_t;
   typedef logic [2:0]             baud_cnt_t;    // 0 .. CLKS_PER_BIT-1
   typedef logic [4:0]             bit_idx_t;     // 0 .. WORD_BITS-1

   typedef enum logic {
      TX_IDLE,
      TX_SEND
   } tx_state_t;

   typedef enum logic [2:0] {
      RX_IDLE,
      RX_START,
      RX_DATA,
      RX_PARITY,
      RX_STOP
   } rx_state_t;

endpackage

// ==== verilog/baud_timer.sv ====
`timescale 1ns/1ps

module baud_timer (
   input  logic clk,
   input  logic rst_n,
   input  logic run,
   input  logic restart,
   output logic bit_tick,
   output logic mid_tick
);

   import uart_pkg::*;

   baud_cnt_t cnt;
   logic      cnt_last;
   logic      cnt_mid;

   assign cnt_last = (cnt == baud_cnt_t'(CLKS_PER_BIT - 1));
   assign cnt_mid  = (cnt == baud_cnt_t'(HALF_BIT - 1));

   // ####################
   // Clock count within one bit
   // ####################
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         cnt <= '0;
      end else if (restart || !run) begin
         cnt <= '0;                                // Hold at bit start
      end else if (cnt_last) begin
         cnt <= '0;
      end else begin
         cnt <= cnt + 1'b1;
      end
   end

   assign bit_tick = run && cnt_last;              // Last clock of a bit
   assign mid_tick = run && cnt_mid;               // Middle of a bit

endmodule

// ==== verilog/tx_frame_fsm.sv ====
`timescale 1ns/1ps

module tx_frame_fsm (
   input  logic clk,
   input  logic rst_n,
   input  logic cmd_vld,
   input  logic bit_tick,
   output logic cmd_rdy,
   output logic load,
   output logic shift,
   output logic timer_run
);

   import uart_pkg::*;

   tx_state_t state;
   tx_state_t state_nxt;
   bit_idx_t  bit_idx;
   logic      last_bit;

   assign last_bit = (bit_idx == bit_idx_t'(WORD_BITS - 1));

   // ####################
   // Handshake and strobes
   // ####################
   assign cmd_rdy   = (state == TX_IDLE);
   assign load      = cmd_vld && cmd_rdy;          // Command taken this clock
   assign timer_run = (state == TX_SEND);
   assign shift     = timer_run && bit_tick;

   always_comb begin
      state_nxt = state;
      case (state)
         TX_IDLE: begin
            if (load) begin
               state_nxt = TX_SEND;
            end
         end
         TX_SEND: begin
            if (shift && last_bit) begin
               state_nxt = TX_IDLE;                // All 22 bits out
            end
         end
         default: state_nxt = TX_IDLE;
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state <= TX_IDLE;
      end else begin
         state <= state_nxt;
      end
   end

   // Index of the bit now on the line
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         bit_idx <= '0;
      end else if (load) begin
         bit_idx <= '0;
      end else if (shift) begin
         bit_idx <= last_bit ? '0 : bit_idx + 1'b1;
      end
   end

endmodule

// ==== verilog/tx_shifter.sv ====
`timescale 1ns/1ps

module tx_shifter (
   input  logic           clk,
   input  logic           rst_n,
   input  uart_pkg::cmd_t cmd_in,
   input  logic           load,
   input  logic           shift,
   output logic           tx
);

   import uart_pkg::*;

   byte_t    hi_byte;
   byte_t    lo_byte;
   logic     hi_par;
   logic     lo_par;
   tx_word_t word;
   tx_word_t framed;

   assign hi_byte = cmd_in[2*DATA_BITS-1:DATA_BITS];
   assign lo_byte = cmd_in[DATA_BITS-1:0];
   assign hi_par  = ~^hi_byte;                     // Odd parity
   assign lo_par  = ~^lo_byte;

   // ####################
   // Two frames, high byte first
   // ####################
   assign framed = {1'b0, hi_byte, hi_par, 1'b1,
                    1'b0, lo_byte, lo_par, 1'b1};

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         word <= '1;                               // Line idles high
      end else if (load) begin
         word <= framed;
      end else if (shift) begin
         word <= {word[WORD_BITS-2:0], 1'b1};
      end
   end

   assign tx = word[WORD_BITS-1];

endmodule

// ==== verilog/rx_frame_fsm.sv ====
`timescale 1ns/1ps

module rx_frame_fsm (
   input  logic clk,
   input  logic rst_n,
   input  logic rx_fall,
   input  logic rx_bit,
   input  logic mid_tick,
   output logic timer_run,
   output logic timer_restart,
   output logic sample,
   output logic frame_done
);

   import uart_pkg::*;

   rx_state_t                      state;
   rx_state_t                      state_nxt;
   logic [$clog2(DATA_BITS)-1:0]   data_cnt;
   logic                           data_last;

   assign data_last = (data_cnt == DATA_BITS - 1);

   assign timer_run     = (state != RX_IDLE);
   assign timer_restart = (state == RX_IDLE) && rx_fall;
   assign sample        = mid_tick && (state == RX_DATA || state == RX_PARITY);
   assign frame_done    = mid_tick && (state == RX_STOP);

   // ####################
   // Frame sequencing
   // ####################
   always_comb begin
      state_nxt = state;
      case (state)
         RX_IDLE:   if (rx_fall)  state_nxt = RX_START;
         RX_START:  if (mid_tick) state_nxt = rx_bit ? RX_IDLE : RX_DATA; // High means glitch
         RX_DATA:   if (mid_tick && data_last) state_nxt = RX_PARITY;
         RX_PARITY: if (mid_tick) state_nxt = RX_STOP;
         RX_STOP:   if (mid_tick) state_nxt = RX_IDLE;
         default:   state_nxt = RX_IDLE;
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state <= RX_IDLE;
      end else begin
         state <= state_nxt;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         data_cnt <= '0;
      end else if (state != RX_DATA) begin
         data_cnt <= '0;
      end else if (mid_tick) begin
         data_cnt <= data_cnt + 1'b1;              // Data bit taken
      end
   end

endmodule

// ==== verilog/rx_shifter.sv ====
`timescale 1ns/1ps

module rx_shifter (
   input  logic            clk,
   input  logic            rst_n,
   input  logic            rx,
   input  logic            sample,
   input  logic            frame_done,
   output logic            rx_bit,
   output logic            rx_fall,
   output uart_pkg::byte_t read_data,
   output logic            read_rdy,
   output logic            rx_err
);

   import uart_pkg::*;

   logic                 rx_meta;
   logic                 rx_sync;
   logic                 rx_prev;
   logic [DATA_BITS:0]   shreg;                    // Data bits then parity
   logic                 frame_ok;

   // ####################
   // Synchronizer and edge
   // ####################
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rx_meta <= 1'b1;
         rx_sync <= 1'b1;
         rx_prev <= 1'b1;
      end else begin
         rx_meta <= rx;
         rx_sync <= rx_meta;
         rx_prev <= rx_sync;
      end
   end

   assign rx_bit  = rx_sync;
   assign rx_fall = rx_prev && !rx_sync;

   always_ff @(posedge clk) begin
      if (sample) begin
         shreg <= {shreg[DATA_BITS-1:0], rx_bit};  // MSB arrives first
      end
   end

   // Stop bit is on the line at frame_done
   assign frame_ok = rx_bit && (^shreg);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         read_data <= '0;
         read_rdy  <= 1'b0;
         rx_err    <= 1'b0;
      end else begin
         read_rdy <= frame_done && frame_ok;
         rx_err   <= frame_done && !frame_ok;
         if (frame_done && frame_ok) begin
            read_data <= shreg[DATA_BITS:1];
         end
      end
   end

endmodule

// ==== verilog/uart_top.sv ====
`timescale 1ns/1ps

module uart_top (
   input  logic            clk,
   input  logic            rst_n,
   input  uart_pkg::cmd_t  cmd_in,
   input  logic            cmd_vld,
   output logic            cmd_rdy,
   output logic            tx,
   input  logic            rx,
   output uart_pkg::byte_t read_data,
   output logic            read_rdy,
   output logic            rx_err
);

   logic tx_load;
   logic tx_shift;
   logic tx_run;
   logic tx_bit_tick;
   logic rx_run;
   logic rx_restart;
   logic rx_mid_tick;
   logic rx_bit;
   logic rx_fall;
   logic rx_sample;
   logic rx_frame_done;

   // ####################
   // Transmit path
   // ####################
   tx_frame_fsm tx_fsm0 (
      .clk       (clk),
      .rst_n     (rst_n),
      .cmd_vld   (cmd_vld),
      .bit_tick  (tx_bit_tick),
      .cmd_rdy   (cmd_rdy),
      .load      (tx_load),
      .shift     (tx_shift),
      .timer_run (tx_run)
   );

   baud_timer tx_timer0 (
      .clk      (clk),
      .rst_n    (rst_n),
      .run      (tx_run),
      .restart  (tx_load),
      .bit_tick (tx_bit_tick),
      .mid_tick ()                                 // Not needed on transmit
   );

   tx_shifter tx_shift0 (
      .clk    (clk),
      .rst_n  (rst_n),
      .cmd_in (cmd_in),
      .load   (tx_load),
      .shift  (tx_shift),
      .tx     (tx)
   );

   // ####################
   // Receive path
   // ####################
   rx_frame_fsm rx_fsm0 (
      .clk           (clk),
      .rst_n         (rst_n),
      .rx_fall       (rx_fall),
      .rx_bit        (rx_bit),
      .mid_tick      (rx_mid_tick),
      .timer_run     (rx_run),
      .timer_restart (rx_restart),
      .sample        (rx_sample),
      .frame_done    (rx_frame_done)
   );

   baud_timer rx_timer0 (
      .clk      (clk),
      .rst_n    (rst_n),
      .run      (rx_run),
      .restart  (rx_restart),
      .bit_tick (),                                // Sampling uses mid-bit only
      .mid_tick (rx_mid_tick)
   );

   rx_shifter rx_shift0 (
      .clk        (clk),
      .rst_n      (rst_n),
      .rx         (rx),
      .sample     (rx_sample),
      .frame_done (rx_frame_done),
      .rx_bit     (rx_bit),
      .rx_fall    (rx_fall),
      .read_data  (read_data),
      .read_rdy   (read_rdy),
      .rx_err     (rx_err)
   );

endmodule

// ==== verif/uart_checker.sv ====
`timescale 1ns/1ps

module uart_checker (
   input logic clk,
   input logic rst_n,
   input logic cmd_vld,
   input logic cmd_rdy,
   input logic tx,
   input logic read_rdy,
   input logic rx_err
);

   import uart_pkg::*;

   localparam int BUSY_CYCLES = WORD_BITS * CLKS_PER_BIT;   // 176 clocks per command

   int fail_cnt = 0;                                         // Read by the testbench

   // ####################
   // Transmit side
   // ####################
   a_busy_len : assert property (
      @(posedge clk) disable iff (!rst_n)
         (cmd_vld && cmd_rdy) |=> (!cmd_rdy) [*BUSY_CYCLES] ##1 cmd_rdy
   ) else begin
      fail_cnt++;
      $error("cmd_rdy did not stay low for exactly %0d cycles after a command", BUSY_CYCLES);
   end

   a_idle_line : assert property (
      @(posedge clk) disable iff (!rst_n) cmd_rdy |-> tx
   ) else begin
      fail_cnt++;
      $error("tx is low while the transmitter is idle");
   end

   // ####################
   // Receive side
   // ####################
   a_rx_excl : assert property (
      @(posedge clk) disable iff (!rst_n) !(read_rdy && rx_err)
   ) else begin
      fail_cnt++;
      $error("read_rdy and rx_err are high in the same cycle");
   end

   a_rdy_pulse : assert property (
      @(posedge clk) disable iff (!rst_n) read_rdy |=> !read_rdy
   ) else begin
      fail_cnt++;
      $error("read_rdy stayed high for more than one cycle");
   end

   a_err_pulse : assert property (
      @(posedge clk) disable iff (!rst_n) rx_err |=> !rx_err
   ) else begin
      fail_cnt++;
      $error("rx_err stayed high for more than one cycle");
   end

endmodule

// ==== verif/uart_tb.sv ====
`timescale 1ns/1ps

module uart_tb;

   import uart_pkg::*;

   localparam int    SEED        = 96886;
   localparam longint WATCHDOG_NS = (30 + 6) * WORD_BITS * CLKS_PER_BIT * 10 * 2;
   localparam int    SETTLE_CYCLES = 2 * WORD_BITS * CLKS_PER_BIT;   // One command plus margin

   logic                     clk = 1'b0;
   logic                     rst_n = 1'b0;
   logic [2*DATA_BITS-1:0]   cmd_in = '0;
   logic                     cmd_vld = 1'b0;
   logic                     cmd_rdy;
   logic                     tx;
   logic                     rx;
   byte_t                    read_data;
   logic                     read_rdy;
   logic                     rx_err;
   logic                     loopback = 1'b1;
   logic                     drv_rx = 1'b1;

   byte_t exp_q[$];                                  // Bytes still to arrive
   int    err_pending = 0;                           // rx_err pulses still due
   int    data_errs = 0;
   int    proto_errs = 0;

   always #5 clk = ~clk;

   assign rx = loopback ? tx : drv_rx;

   uart_top dut0 (.*);

   bind uart_top uart_checker chk0 (.*);

   // ####################
   // Scoreboard
   // ####################
   always @(posedge clk) begin
      byte_t exp_byte;
      if (rst_n) begin
         if (cmd_vld && cmd_rdy) begin
            exp_q.push_back(cmd_in[2*DATA_BITS-1:DATA_BITS]);   // High byte goes first
            exp_q.push_back(cmd_in[DATA_BITS-1:0]);
         end
         if (read_rdy) begin
            assert (exp_q.size() > 0) else begin
               proto_errs++;
               $display("Byte %02h arrived at %0t with nothing pending", read_data, $time);
            end
            if (exp_q.size() > 0) begin
               exp_byte = exp_q.pop_front();
               assert (read_data == exp_byte) else begin
                  data_errs++;
                  $display("FAIL %0t: read_data %02h, expected %02h",
                           $time, read_data, exp_byte);
               end
            end
         end
         if (rx_err) begin
            assert (err_pending > 0) else begin
               proto_errs++;
               $display("Unexpected rx_err at %0t", $time);
            end
            if (err_pending > 0) begin
               err_pending--;
            end
         end
      end
   end

   // ####################
   // Stimulus tasks
   // ####################
   task automatic send_cmd(input logic [2*DATA_BITS-1:0] value);
      while (!cmd_rdy) begin
         @(posedge clk);
         #1;
      end
      cmd_in  = value;
      cmd_vld = 1'b1;
      @(posedge clk);                                // Taken on this edge
      #1;
      cmd_vld = 1'b0;
   endtask

   task automatic send_frame(input byte_t data, input logic par_ok, input logic stop_bit);
      logic [FRAME_BITS-1:0] bits;
      logic                  par;
      par  = par_ok ? ~^data : ^data;                // Odd count of ones when good
      bits = {1'b0, data, par, stop_bit};
      if (par_ok && stop_bit) begin
         exp_q.push_back(data);
      end else begin
         err_pending++;
      end
      for (int i = FRAME_BITS - 1; i >= 0; i--) begin
         drv_rx = bits[i];
         repeat (CLKS_PER_BIT) @(posedge clk);
         #1;
      end
      drv_rx = 1'b1;
   endtask

   task automatic wait_settled();
      int waited;
      waited = 0;
      while ((exp_q.size() != 0 || err_pending != 0) && waited < SETTLE_CYCLES) begin
         @(posedge clk);
         #1;
         waited++;
      end
      if (exp_q.size() != 0 || err_pending != 0) begin
         proto_errs++;
         $display("%0d bytes and %0d errors never arrived by %0t",
                  exp_q.size(), err_pending, $time);
         exp_q.delete();
         err_pending = 0;
      end
      repeat (2 * CLKS_PER_BIT) @(posedge clk);      // Idle gap on the line
      #1;
   endtask

   // ####################
   // Main sequence
   // ####################
   initial begin
      int unsigned rnd;
      int          total;
      void'($urandom(SEED));
      repeat (10) @(posedge clk);
      #1;
      rst_n = 1'b1;
      repeat (2) @(posedge clk);
      #1;

      send_cmd(16'hA53C);
      wait_settled();

      for (int n = 0; n < 20; n++) begin
         rnd = $urandom;
         send_cmd(rnd[2*DATA_BITS-1:0]);
      end
      wait_settled();

      send_cmd(16'h1234);
      repeat (5 * CLKS_PER_BIT) @(posedge clk);
      #1;
      assert (!cmd_rdy) else begin
         proto_errs++;
         $display("Transmitter was idle when the busy request was made");
      end
      cmd_in  = 16'hFFFF;                            // Must be ignored
      cmd_vld = 1'b1;
      @(posedge clk);
      #1;
      cmd_vld = 1'b0;
      wait_settled();

      loopback = 1'b0;
      send_frame(8'h5A, 1'b0, 1'b1);
      wait_settled();
      send_frame(8'hC3, 1'b1, 1'b0);
      wait_settled();
      send_frame(8'h81, 1'b1, 1'b1);
      wait_settled();

      drv_rx = 1'b0;                                 // Two-cycle glitch
      repeat (2) @(posedge clk);
      #1;
      drv_rx = 1'b1;
      repeat (2 * CLKS_PER_BIT) @(posedge clk);
      #1;
      send_frame(8'h3E, 1'b1, 1'b1);
      wait_settled();

      total = data_errs + proto_errs + dut0.chk0.fail_cnt;
      $display("Errors: data %0d, protocol %0d, assertion %0d",
               data_errs, proto_errs, dut0.chk0.fail_cnt);
      if (total == 0) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

   initial begin
      #(WATCHDOG_NS);
      $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
      $display("sim failed");
      $finish;
   end

endmodule

// ==== build.f ====
verilog/uart_pkg.sv
verilog/baud_timer.sv
verilog/tx_frame_fsm.sv
verilog/tx_shifter.sv
verilog/rx_frame_fsm.sv
verilog/rx_shifter.sv
verilog/uart_top.sv
verif/uart_checker.sv
verif/uart_tb.sv
